/* mem_types_pkg.sv */
`default_nettype none

package mem_types_pkg;

    // Memory geometry, fixed by the RV32 access rules
    localparam int LANES     = 4;    // Byte lanes per word
    localparam int MEM_WORDS = 256;  // 1 KiB of data RAM
    localparam int WORD_AW   = 8;    // Word index width

    typedef logic [31:0] data_t;       // One data word
    typedef logic [31:0] data_addr_t;  // Byte address
    typedef logic [LANES-1:0] byte_en_t;

    // Access size from the core
    typedef enum logic [1:0] {
        ACCESS_BYTE = 2'b00,
        ACCESS_HALF = 2'b01,
        ACCESS_WORD = 2'b10
    } data_access_e;

    // APB master phases
    typedef enum logic [1:0] {
        APB_IDLE   = 2'b00,
        APB_SETUP  = 2'b01,
        APB_ACCESS = 2'b10
    } apb_state_e;

endpackage

`default_nettype wire

/* data_memory_adapter.sv */
`timescale 1ns/10ps
`default_nettype none

module data_memory_adapter (
    input  mem_types_pkg::data_addr_t   i_addr,         // Byte address
    input  mem_types_pkg::data_access_e i_access,       // Byte, half or word
    input  logic                        i_unsigned,     // Zero-extend loads
    input  logic                        i_wr_enable,
    input  logic                        i_rd_enable,
    input  mem_types_pkg::data_t        i_wr_data,
    input  mem_types_pkg::data_t        i_bus_rdata,    // Word from the bus
    input  logic                        i_bus_busy,
    output mem_types_pkg::data_t        o_rd_data,      // Extended load result
    output logic                        o_busy,
    output logic                        o_align_error,
    output mem_types_pkg::data_addr_t   o_bus_addr,     // Word aligned
    output logic                        o_bus_we,
    output logic                        o_bus_re,
    output mem_types_pkg::byte_en_t     o_bus_be,
    output mem_types_pkg::data_t        o_bus_wdata     // Lane steered
);
    import mem_types_pkg::*;

    logic [1:0] offset;   // Byte offset inside the word
    data_t      rd_lane;  // Read word moved down to the addressed byte

    assign offset  = i_addr[1:0];
    assign rd_lane = i_bus_rdata >> {offset, 3'b000};

    assign o_busy     = i_bus_busy;
    assign o_bus_addr = {i_addr[31:2], 2'b00};
    assign o_bus_we   = i_wr_enable & ~o_align_error;  // Misaligned never reaches bus
    assign o_bus_re   = i_rd_enable & ~o_align_error;

    // Half needs an even address, word a multiple of 4
    always_comb begin
        case (i_access)
            ACCESS_BYTE: begin
                o_align_error = 1'b0;
            end
            ACCESS_HALF: begin
                o_align_error = offset[0];
            end
            ACCESS_WORD: begin
                o_align_error = |offset;
            end
            default: begin
                o_align_error = 1'b1;  // Unknown size is refused
            end
        endcase
    end

    // Store steering and byte enables
    always_comb begin
        o_bus_wdata = '0;
        o_bus_be    = '0;
        case (i_access)
            ACCESS_BYTE: begin
                o_bus_wdata = data_t'(i_wr_data[7:0]) << {offset, 3'b000};
                o_bus_be    = byte_en_t'(4'b0001) << offset;
            end
            ACCESS_HALF: begin
                o_bus_wdata = data_t'(i_wr_data[15:0]) << {offset[1], 4'b0000};
                o_bus_be    = byte_en_t'(4'b0011) << {offset[1], 1'b0};
            end
            ACCESS_WORD: begin
                o_bus_wdata = i_wr_data;
                o_bus_be    = 4'b1111;
            end
            default: begin
                o_bus_be = '0;
            end
        endcase
    end

    // Load lane pick and extension
    always_comb begin
        case (i_access)
            ACCESS_BYTE: begin
                o_rd_data = {i_unsigned ? 24'b0 : {24{rd_lane[7]}}, rd_lane[7:0]};
            end
            ACCESS_HALF: begin
                o_rd_data = {i_unsigned ? 16'b0 : {16{rd_lane[15]}}, rd_lane[15:0]};
            end
            default: begin
                o_rd_data = i_bus_rdata;  // Full word, offset is zero
            end
        endcase
    end

endmodule

`default_nettype wire

/* apb_bridge.sv */
`timescale 1ns/10ps
`default_nettype none

module apb_bridge (
    input  logic                      i_clock,
    input  logic                      i_arst_n,
    input  mem_types_pkg::data_addr_t i_bus_addr,
    input  logic                      i_bus_we,
    input  logic                      i_bus_re,
    input  mem_types_pkg::byte_en_t   i_bus_be,
    input  mem_types_pkg::data_t      i_bus_wdata,
    output mem_types_pkg::data_t      o_bus_rdata,
    output logic                      o_bus_busy,
    output logic                      o_bus_err,
    output logic                      o_psel,
    output logic                      o_penable,
    output logic                      o_pwrite,
    output mem_types_pkg::data_addr_t o_paddr,
    output mem_types_pkg::data_t      o_pwdata,
    output mem_types_pkg::byte_en_t   o_pstrb,
    input  mem_types_pkg::data_t      i_prdata,
    input  logic                      i_pready,
    input  logic                      i_pslverr
);
    import mem_types_pkg::*;

    apb_state_e state;
    apb_state_e state_next;
    logic       start;  // Request accepted in IDLE
    logic       done;   // Completion cycle

    assign start = (state == APB_IDLE) & (i_bus_we | i_bus_re);
    assign done  = (state == APB_ACCESS) & i_pready;

    always_comb begin
        state_next = state;
        case (state)
            APB_IDLE: begin
                if (start) begin
                    state_next = APB_SETUP;
                end
            end
            APB_SETUP: begin
                state_next = APB_ACCESS;
            end
            APB_ACCESS: begin
                if (i_pready) begin
                    state_next = APB_IDLE;  // Slave may stretch ACCESS
                end
            end
            default: begin
                state_next = APB_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state <= APB_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Transfer fields held stable until completion
    always_ff @(posedge i_clock) begin
        if (start) begin
            o_paddr  <= i_bus_addr;
            o_pwrite <= i_bus_we;                   // Write wins over read
            o_pwdata <= i_bus_wdata;
            o_pstrb  <= i_bus_we ? i_bus_be : '0;   // No strobes on reads
        end
    end

    assign o_psel      = (state != APB_IDLE);
    assign o_penable   = (state == APB_ACCESS);
    assign o_bus_busy  = (state == APB_SETUP) | ((state == APB_ACCESS) & ~i_pready);
    assign o_bus_rdata = done ? i_prdata : '0;
    assign o_bus_err   = done & i_pslverr;

endmodule

`default_nettype wire

/* apb_mem_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module apb_mem_decoder (
    input  logic                              i_clock,
    input  logic                              i_arst_n,
    input  logic                              i_psel,
    input  logic                              i_penable,
    input  logic                              i_pwrite,
    input  mem_types_pkg::data_addr_t         i_paddr,
    input  mem_types_pkg::data_t              i_pwdata,
    input  mem_types_pkg::byte_en_t           i_pstrb,
    output logic [mem_types_pkg::LANES-1:0]   o_lane_en,
    output logic [mem_types_pkg::LANES-1:0]   o_lane_we,
    output logic [mem_types_pkg::WORD_AW-1:0] o_lane_addr,     // Shared word index
    output mem_types_pkg::data_t              o_lane_wdata,    // One byte per lane
    output logic                              o_access_first,
    output logic                              o_range_err
);
    import mem_types_pkg::*;

    logic access_seen;   // ACCESS already served this transfer
    logic out_of_range;  // Address beyond the 1 KiB window

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            access_seen <= 1'b0;
        end else begin
            access_seen <= i_psel & i_penable;
        end
    end

    assign o_access_first = i_psel & i_penable & ~access_seen;

    // paddr comes from the bridge register, so the flag is clean
    assign out_of_range = |(i_paddr >> (WORD_AW + 2));
    assign o_range_err  = o_access_first & out_of_range;

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            o_lane_en[i] = o_access_first & ~out_of_range & (~i_pwrite | i_pstrb[i]);
            o_lane_we[i] = o_access_first & ~out_of_range & i_pwrite & i_pstrb[i];
        end
    end

    assign o_lane_addr  = i_paddr[WORD_AW+1:2];
    assign o_lane_wdata = i_pwdata;

endmodule

`default_nettype wire

/* byte_lane_ram.sv */
`timescale 1ns/10ps
`default_nettype none

module byte_lane_ram (
    input  logic                              i_clock,
    input  logic                              i_en,
    input  logic                              i_we,
    input  logic [mem_types_pkg::WORD_AW-1:0] i_addr,
    input  logic [7:0]                        i_wdata,
    output logic [7:0]                        o_rdata   // Valid the cycle after i_en
);
    import mem_types_pkg::*;

    logic [7:0] mem [MEM_WORDS];

    always_ff @(posedge i_clock) begin
        if (i_en) begin
            if (i_we) begin
                mem[i_addr] <= i_wdata;
            end
            o_rdata <= mem[i_addr];  // Old contents on a write
        end
    end

endmodule

`default_nettype wire

/* apb_read_merge.sv */
`timescale 1ns/10ps
`default_nettype none

module apb_read_merge (
    input  logic                 i_clock,
    input  logic                 i_arst_n,
    input  mem_types_pkg::data_t i_lane_rdata,    // Lane i in byte i
    input  logic                 i_access_first,
    input  logic                 i_range_err,
    output mem_types_pkg::data_t o_prdata,
    output logic                 o_pready,
    output logic                 o_pslverr
);
    import mem_types_pkg::*;

    // Lanes answer one edge after the first ACCESS cycle
    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_pready  <= 1'b0;
            o_pslverr <= 1'b0;
        end else begin
            o_pready  <= i_access_first;
            o_pslverr <= i_range_err;
        end
    end

    always_comb begin
        o_prdata = '0;
        for (int i = 0; i < LANES; i++) begin
            o_prdata[8*i +: 8] = o_pslverr ? 8'h00 : i_lane_rdata[8*i +: 8];  // Zero on error
        end
    end

endmodule

`default_nettype wire

/* data_mem_subsystem.sv */
`timescale 1ns/10ps
`default_nettype none

module data_mem_subsystem (
    input  logic                        i_clock,
    input  logic                        i_arst_n,
    input  mem_types_pkg::data_addr_t   i_addr,
    input  mem_types_pkg::data_access_e i_access,
    input  logic                        i_unsigned,
    input  logic                        i_wr_enable,
    input  logic                        i_rd_enable,
    input  mem_types_pkg::data_t        i_wr_data,
    output mem_types_pkg::data_t        o_rd_data,
    output logic                        o_busy,
    output logic                        o_align_error,
    output logic                        o_bus_error
);
    import mem_types_pkg::*;

    // Core bus between adapter and bridge
    data_addr_t bus_addr;
    byte_en_t   bus_be;
    data_t      bus_wdata;
    logic       bus_we;
    logic       bus_re;
    data_t      bus_rdata;
    logic       bus_busy;

    // APB
    logic       psel;
    logic       penable;
    logic       pwrite;
    data_addr_t paddr;
    data_t      pwdata;
    byte_en_t   pstrb;
    data_t      prdata;
    logic       pready;
    logic       pslverr;

    // Byte lanes
    logic [LANES-1:0]   lane_en;
    logic [LANES-1:0]   lane_we;
    logic [WORD_AW-1:0] lane_addr;
    data_t              lane_wdata;
    data_t              lane_rdata;
    logic               access_first;
    logic               range_err;

    data_memory_adapter u_data_memory_adapter (
        .i_addr        (i_addr),
        .i_access      (i_access),
        .i_unsigned    (i_unsigned),
        .i_wr_enable   (i_wr_enable),
        .i_rd_enable   (i_rd_enable),
        .i_wr_data     (i_wr_data),
        .i_bus_rdata   (bus_rdata),
        .i_bus_busy    (bus_busy),
        .o_rd_data     (o_rd_data),
        .o_busy        (o_busy),
        .o_align_error (o_align_error),
        .o_bus_addr    (bus_addr),
        .o_bus_we      (bus_we),
        .o_bus_re      (bus_re),
        .o_bus_be      (bus_be),
        .o_bus_wdata   (bus_wdata)
    );

    apb_bridge u_apb_bridge (
        .i_clock     (i_clock),
        .i_arst_n    (i_arst_n),
        .i_bus_addr  (bus_addr),
        .i_bus_we    (bus_we),
        .i_bus_re    (bus_re),
        .i_bus_be    (bus_be),
        .i_bus_wdata (bus_wdata),
        .o_bus_rdata (bus_rdata),
        .o_bus_busy  (bus_busy),
        .o_bus_err   (o_bus_error),  // Slave error goes straight to the core
        .o_psel      (psel),
        .o_penable   (penable),
        .o_pwrite    (pwrite),
        .o_paddr     (paddr),
        .o_pwdata    (pwdata),
        .o_pstrb     (pstrb),
        .i_prdata    (prdata),
        .i_pready    (pready),
        .i_pslverr   (pslverr)
    );

    apb_mem_decoder u_apb_mem_decoder (
        .i_clock        (i_clock),
        .i_arst_n       (i_arst_n),
        .i_psel         (psel),
        .i_penable      (penable),
        .i_pwrite       (pwrite),
        .i_paddr        (paddr),
        .i_pwdata       (pwdata),
        .i_pstrb        (pstrb),
        .o_lane_en      (lane_en),
        .o_lane_we      (lane_we),
        .o_lane_addr    (lane_addr),
        .o_lane_wdata   (lane_wdata),
        .o_access_first (access_first),
        .o_range_err    (range_err)
    );

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        byte_lane_ram u_byte_lane_ram (
            .i_clock (i_clock),
            .i_en    (lane_en[i]),
            .i_we    (lane_we[i]),
            .i_addr  (lane_addr),
            .i_wdata (lane_wdata[8*i +: 8]),
            .o_rdata (lane_rdata[8*i +: 8])
        );
    end

    apb_read_merge u_apb_read_merge (
        .i_clock        (i_clock),
        .i_arst_n       (i_arst_n),
        .i_lane_rdata   (lane_rdata),
        .i_access_first (access_first),
        .i_range_err    (range_err),
        .o_prdata       (prdata),
        .o_pready       (pready),
        .o_pslverr      (pslverr)
    );

endmodule

`default_nettype wire

/* data_mem_properties.sv */
`timescale 1ns/10ps
`default_nettype none

module data_mem_properties (
    input logic                      i_clock,
    input logic                      i_arst_n,
    input logic                      i_busy,
    input logic                      i_align_error,
    input logic                      i_psel,
    input logic                      i_penable,
    input logic                      i_pready,
    input mem_types_pkg::apb_state_e i_state   // Bridge FSM state
);
    import mem_types_pkg::*;

    a_busy_in_reset : assert property (@(posedge i_clock) !i_arst_n |-> !i_busy)
        else $error("o_busy high while reset is asserted");

    // A refused access arriving in idle must not open a transfer
    a_no_psel_misaligned : assert property (@(posedge i_clock) disable iff (!i_arst_n)
        (i_align_error && !i_psel) |=> !i_psel)
        else $error("psel raised for a misaligned access");

    a_penable_after_setup : assert property (@(posedge i_clock) disable iff (!i_arst_n)
        $rose(i_penable) |-> $past(i_psel && !i_penable && (i_state == APB_SETUP)))
        else $error("penable rose without a preceding SETUP cycle");

    a_pready_in_access : assert property (@(posedge i_clock) disable iff (!i_arst_n)
        i_pready |-> i_penable)
        else $error("pready high outside an ACCESS cycle");

endmodule

bind data_mem_subsystem data_mem_properties u_data_mem_properties (
    .i_clock       (i_clock),
    .i_arst_n      (i_arst_n),
    .i_busy        (o_busy),
    .i_align_error (o_align_error),
    .i_psel        (psel),
    .i_penable     (penable),
    .i_pready      (pready),
    .i_state       (u_apb_bridge.state)
);

`default_nettype wire

/* tb_data_mem_subsystem.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_data_mem_subsystem;
    import mem_types_pkg::*;

    localparam int   RESET_CYCLES = 8;
    localparam int   BUSY_LIMIT   = 8;  // Cycles before o_busy counts as stuck
    localparam int   LATENCY      = 3;  // SETUP, ACCESS, ACCESS with pready
    localparam logic WR           = 1'b1;
    localparam logic RD           = 1'b0;

    typedef struct {
        string        name;
        logic         is_write;
        data_access_e access;
        logic         is_unsigned;
        data_addr_t   addr;
        data_t        wdata;
        data_t        exp_rd;
        logic         exp_align;
        logic         exp_berr;
    } test_t;

    logic         i_clock;
    logic         i_arst_n;
    data_addr_t   i_addr;
    data_access_e i_access;
    logic         i_unsigned;
    logic         i_wr_enable;
    logic         i_rd_enable;
    data_t        i_wr_data;
    data_t        o_rd_data;
    logic         o_busy;
    logic         o_align_error;
    logic         o_bus_error;

    test_t  tests[$];
    data_t  rand_words[3];      // Seeded store data for the word round trip
    integer seed        = 92;
    int     error_count = 0;
    int     pass_count  = 0;
    int     fail_count  = 0;
    int     cycle_count = 0;
    int     cycle_limit = 1000;  // Replaced once the table is built

    data_mem_subsystem u_data_mem_subsystem (
        .i_clock       (i_clock),
        .i_arst_n      (i_arst_n),
        .i_addr        (i_addr),
        .i_access      (i_access),
        .i_unsigned    (i_unsigned),
        .i_wr_enable   (i_wr_enable),
        .i_rd_enable   (i_rd_enable),
        .i_wr_data     (i_wr_data),
        .o_rd_data     (o_rd_data),
        .o_busy        (o_busy),
        .o_align_error (o_align_error),
        .o_bus_error   (o_bus_error)
    );

    always #10 i_clock = ~i_clock;  // 20 ns period

    always @(posedge i_clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: run did not end within %0d cycles", cycle_limit);
            $display("sim failed");
            $finish;
        end
    end

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (exp !== act) begin
            $display("** Error %s: expected %h, actual %h", name, exp, act);
            error_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("** Error %s: expected %b, actual %b", name, exp, act);
            error_count++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (exp != act) begin
            $display("** Error %s: expected %0d cycles, actual %0d cycles", name, exp, act);
            error_count++;
        end
    endtask

    task automatic add_test(input string name, input logic is_write, input data_access_e access,
                            input logic is_unsigned, input data_addr_t addr, input data_t wdata,
                            input data_t exp_rd, input logic exp_align, input logic exp_berr);
        test_t t;
        t.name        = name;
        t.is_write    = is_write;
        t.access      = access;
        t.is_unsigned = is_unsigned;
        t.addr        = addr;
        t.wdata       = wdata;
        t.exp_rd      = exp_rd;
        t.exp_align   = exp_align;
        t.exp_berr    = exp_berr;
        tests.push_back(t);
    endtask

    task automatic build_table();
        for (int i = 0; i < 3; i++) begin
            rand_words[i] = $random(seed);
        end
        // Word round trip, top word included
        add_test("wr_word_000", WR, ACCESS_WORD, 0, 32'h000, rand_words[0], '0, 0, 0);
        add_test("wr_word_004", WR, ACCESS_WORD, 0, 32'h004, rand_words[1], '0, 0, 0);
        add_test("wr_word_3fc", WR, ACCESS_WORD, 0, 32'h3fc, rand_words[2], '0, 0, 0);
        add_test("rd_word_000", RD, ACCESS_WORD, 0, 32'h000, '0, rand_words[0], 0, 0);
        add_test("rd_word_004", RD, ACCESS_WORD, 0, 32'h004, '0, rand_words[1], 0, 0);
        add_test("rd_word_3fc", RD, ACCESS_WORD, 0, 32'h3fc, '0, rand_words[2], 0, 0);
        // Byte stores into 0x010, one lane each
        add_test("wr_base_010", WR, ACCESS_WORD, 0, 32'h010, 32'h11223344, '0, 0, 0);
        add_test("wr_byte_010", WR, ACCESS_BYTE, 0, 32'h010, 32'hffffffa5, '0, 0, 0);
        add_test("rd_byte0_mrg", RD, ACCESS_WORD, 0, 32'h010, '0, 32'h112233a5, 0, 0);
        add_test("wr_byte_011", WR, ACCESS_BYTE, 0, 32'h011, 32'h0000005a, '0, 0, 0);
        add_test("wr_byte_012", WR, ACCESS_BYTE, 0, 32'h012, 32'habcdefc3, '0, 0, 0);
        add_test("wr_byte_013", WR, ACCESS_BYTE, 0, 32'h013, 32'h000000e7, '0, 0, 0);
        add_test("rd_all_mrg", RD, ACCESS_WORD, 0, 32'h010, '0, 32'he7c35aa5, 0, 0);
        // Narrow loads from e7c35aa5
        add_test("ld_byte0_s", RD, ACCESS_BYTE, 0, 32'h010, '0, 32'hffffffa5, 0, 0);
        add_test("ld_byte0_u", RD, ACCESS_BYTE, 1, 32'h010, '0, 32'h000000a5, 0, 0);
        add_test("ld_byte2_s", RD, ACCESS_BYTE, 0, 32'h012, '0, 32'hffffffc3, 0, 0);
        add_test("ld_byte3_u", RD, ACCESS_BYTE, 1, 32'h013, '0, 32'h000000e7, 0, 0);
        add_test("ld_half0_s", RD, ACCESS_HALF, 0, 32'h010, '0, 32'h00005aa5, 0, 0);
        add_test("ld_half2_s", RD, ACCESS_HALF, 0, 32'h012, '0, 32'hffffe7c3, 0, 0);
        add_test("ld_half2_u", RD, ACCESS_HALF, 1, 32'h012, '0, 32'h0000e7c3, 0, 0);
        // Half stores into 0x020
        add_test("wr_base_020", WR, ACCESS_WORD, 0, 32'h020, 32'hcafef00d, '0, 0, 0);
        add_test("wr_half_020", WR, ACCESS_HALF, 0, 32'h020, 32'hffff1234, '0, 0, 0);
        add_test("rd_half0_mrg", RD, ACCESS_WORD, 0, 32'h020, '0, 32'hcafe1234, 0, 0);
        add_test("wr_half_022", WR, ACCESS_HALF, 0, 32'h022, 32'h0000beef, '0, 0, 0);
        add_test("rd_half2_mrg", RD, ACCESS_WORD, 0, 32'h020, '0, 32'hbeef1234, 0, 0);
        // Misaligned requests never reach the RAM
        add_test("mis_half_wr", WR, ACCESS_HALF, 0, 32'h021, 32'h00005555, '0, 1, 0);
        add_test("mis_word_wr", WR, ACCESS_WORD, 0, 32'h022, 32'h66666666, '0, 1, 0);
        add_test("mis_word_rd", RD, ACCESS_WORD, 0, 32'h012, '0, '0, 1, 0);
        add_test("rd_after_mis", RD, ACCESS_WORD, 0, 32'h020, '0, 32'hbeef1234, 0, 0);
        // 0x400 would alias word 0 without the range check
        add_test("oor_wr_400", WR, ACCESS_WORD, 0, 32'h400, 32'hdeadbeef, '0, 0, 1);
        add_test("oor_rd_404", RD, ACCESS_WORD, 0, 32'h404, '0, '0, 0, 1);
        add_test("rd_alias_000", RD, ACCESS_WORD, 0, 32'h000, '0, rand_words[0], 0, 0);
    endtask

    task automatic run_test(input test_t t);
        int cycles;
        int errors_before;
        errors_before = error_count;
        i_addr        = t.addr;
        i_access      = t.access;
        i_unsigned    = t.is_unsigned;
        i_wr_data     = t.wdata;
        i_wr_enable   = t.is_write;
        i_rd_enable   = ~t.is_write;
        if (t.exp_align) begin
            #5;  // Mid low phase, before the next rising edge
            check_flag({t.name, " align"}, 1'b1, o_align_error);
            @(negedge i_clock);
            check_flag({t.name, " busy"}, 1'b0, o_busy);
            check_flag({t.name, " bus error"}, 1'b0, o_bus_error);
        end else begin
            cycles = 0;
            do begin
                @(negedge i_clock);
                cycles++;
            end while (o_busy && cycles < BUSY_LIMIT);
            if (o_busy) begin
                $display("test %s: o_busy still high after %0d cycles", t.name, cycles);
                error_count++;
            end else begin
                check_count({t.name, " latency"}, LATENCY, cycles);
                check_flag({t.name, " align"}, 1'b0, o_align_error);
                check_flag({t.name, " bus error"}, t.exp_berr, o_bus_error);
                if (!t.is_write || t.exp_berr) begin
                    check_data({t.name, " data"}, t.exp_rd, o_rd_data);
                end
            end
        end
        i_wr_enable = 1'b0;  // Drop before the edge that ends the transfer
        i_rd_enable = 1'b0;
        @(negedge i_clock);
        if (error_count == errors_before) begin
            pass_count++;
            $display("test %s: ok", t.name);
        end else begin
            fail_count++;
            $display("test %s: mismatch", t.name);
        end
    endtask

    initial begin
        i_clock     = 1'b0;
        i_arst_n    = 1'b0;
        i_addr      = '0;
        i_access    = ACCESS_WORD;
        i_unsigned  = 1'b0;
        i_wr_enable = 1'b0;
        i_rd_enable = 1'b0;
        i_wr_data   = '0;
        build_table();
        cycle_limit = tests.size() * 8 + RESET_CYCLES + 20;
        repeat (RESET_CYCLES) @(negedge i_clock);
        check_flag("reset busy", 1'b0, o_busy);
        i_arst_n = 1'b1;
        @(negedge i_clock);
        foreach (tests[i]) begin
            run_test(tests[i]);
        end
        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0 && error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* data_mem_subsystem.f */
mem_types_pkg.sv
data_memory_adapter.sv
apb_bridge.sv
apb_mem_decoder.sv
byte_lane_ram.sv
apb_read_merge.sv
data_mem_subsystem.sv
data_mem_properties.sv
tb_data_mem_subsystem.sv

/* Makefile */
SOURCES := $(wildcard *.sv)
SIM     := obj_dir/Vtb_data_mem_subsystem

.PHONY: run clean

run: $(SIM)
	$(SIM) | tee sim.log
	grep -qx "sim passed" sim.log

$(SIM): $(SOURCES) data_mem_subsystem.f
	verilator --binary --timing --assert --top-module tb_data_mem_subsystem \
		-f data_mem_subsystem.f

clean:
	rm -rf obj_dir sim.log
